// ==== hdl/mem_pkg.sv ====
package mem_pkg;

    typedef logic [31:0] word_t;   // data or instruction word
    typedef logic [31:0] mask_t;   // 1 = bit is written
    typedef logic [31:0] addr_t;   // byte address
    typedef logic [63:0] mtime_t;  // full width of mtime / mtimecmp

    typedef enum logic [1:0] {
        wait_cmd   = 2'd0,
        wait_ready = 2'd1,
        wait_read  = 2'd2
    } arb_state_t;

    // memory map
    localparam addr_t TIMER_BASE    = 32'hf000_0000;
    localparam word_t READ_ALL_ONES = 32'hffff_ffff;

    // timer register select, byte offset / 4
    localparam logic [1:0] TMR_MTIME_LO = 2'd0;
    localparam logic [1:0] TMR_MTIME_HI = 2'd1;
    localparam logic [1:0] TMR_CMP_LO   = 2'd2;
    localparam logic [1:0] TMR_CMP_HI   = 2'd3;

    // masked merge shared by the RAM and the timer registers
    function automatic word_t merge_word(
        input word_t old_word,
        input word_t new_word,
        input mask_t mask
    );
        return (old_word & ~mask) | (new_word & mask);
    endfunction

endpackage

// ==== hdl/word_ram.sv ====
`timescale 1ns/100ps

module word_ram
    import mem_pkg::*;
#(
    parameter int MEM_WORDS = 1024
) (
    input  logic                         clk,
    input  logic                         ram_we,
    input  logic                         ram_re,
    input  logic [$clog2(MEM_WORDS)-1:0] ram_index,
    input  word_t                        ram_wdata,
    input  mask_t                        ram_wmask,
    output word_t                        ram_rdata
);

    word_t mem [MEM_WORDS];

    // contents start cleared
    initial begin
        for (int i = 0; i < MEM_WORDS; i++) begin
            mem[i] = '0;
        end
    end

    // per-bit masked write
    always_ff @(posedge clk) begin
        if (ram_we) begin
            mem[ram_index] <= merge_word(mem[ram_index], ram_wdata, ram_wmask);
        end
    end

    always_ff @(posedge clk) begin
        if (ram_re) begin
            ram_rdata <= mem[ram_index];  // one cycle latency
        end
    end

endmodule

// ==== hdl/timer_regs.sv ====
`timescale 1ns/100ps

module timer_regs
    import mem_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  logic       tmr_we,
    input  logic [1:0] tmr_sel,
    input  word_t      tmr_wdata,
    input  mask_t      tmr_mask,
    output word_t      tmr_rdata,
    output logic       timer_irq
);

    mtime_t mtime;
    mtime_t mtimecmp;
    mtime_t mtime_inc;

    assign mtime_inc = mtime + 64'd1;

    always_ff @(posedge clk) begin
        if (rst) begin
            mtime     <= '0;
            mtimecmp  <= '1;  // far future
            timer_irq <= 1'b0;
        end else begin
            mtime     <= mtime_inc;           // free running
            timer_irq <= (mtime >= mtimecmp); // unsigned compare
            if (tmr_we) begin
                // a written half overrides the increment
                case (tmr_sel)
                    TMR_MTIME_LO: mtime[31:0] <= merge_word(mtime_inc[31:0], tmr_wdata, tmr_mask);
                    TMR_MTIME_HI:
                        mtime[63:32] <= merge_word(mtime_inc[63:32], tmr_wdata, tmr_mask);
                    TMR_CMP_LO: mtimecmp[31:0] <= merge_word(mtimecmp[31:0], tmr_wdata, tmr_mask);
                    TMR_CMP_HI:
                        mtimecmp[63:32] <= merge_word(mtimecmp[63:32], tmr_wdata, tmr_mask);
                    default: ;
                endcase
            end
        end
    end

    always_comb begin
        case (tmr_sel)
            TMR_MTIME_LO: tmr_rdata = mtime[31:0];
            TMR_MTIME_HI: tmr_rdata = mtime[63:32];
            TMR_CMP_LO:   tmr_rdata = mtimecmp[31:0];
            default:      tmr_rdata = mtimecmp[63:32];
        endcase
    end

endmodule

// ==== hdl/mem_map_ctrl.sv ====
`timescale 1ns/100ps

module mem_map_ctrl
    import mem_pkg::*;
#(
    parameter int MEM_WORDS = 1024
) (
    input  logic  clk,
    input  logic  rst,

    // port from the arbiter
    input  logic  mem_cmd_start,
    input  logic  mem_cmd_write,
    output logic  mem_cmd_ready,
    input  addr_t mem_addr,
    input  word_t mem_wdata,
    input  mask_t mem_wmask,
    output word_t mem_rdata,
    output logic  mem_rdata_valid,

    // word RAM
    output logic                         ram_we,
    output logic                         ram_re,
    output logic [$clog2(MEM_WORDS)-1:0] ram_index,
    output word_t                        ram_wdata,
    output mask_t                        ram_wmask,
    input  word_t                        ram_rdata,

    // timer block
    output logic       tmr_we,
    output logic [1:0] tmr_sel,
    output word_t      tmr_wdata,
    input  word_t      tmr_rdata
);

    localparam int    IDX_W     = $clog2(MEM_WORDS);
    localparam addr_t RAM_LIMIT = addr_t'(MEM_WORDS * 4);

    logic  in_ram;
    logic  in_tmr;
    logic  accept;
    logic  wr_accept;
    logic  rd_accept;

    logic  rd_p1;   // read in stage 1
    logic  p1_ram;  // region of the stage 1 read
    logic  p1_tmr;
    word_t tmr_q;   // timer word sampled at accept

    // region decode, low two address bits ignored
    assign in_ram = (mem_addr < RAM_LIMIT);
    assign in_tmr = (mem_addr[31:4] == TIMER_BASE[31:4]);

    assign accept    = mem_cmd_start && mem_cmd_ready;
    assign wr_accept = accept && mem_cmd_write;
    assign rd_accept = accept && !mem_cmd_write;

    // writes to unmapped space fall through here
    assign ram_we    = wr_accept && in_ram;
    assign ram_re    = rd_accept && in_ram;
    assign ram_index = mem_addr[IDX_W+1:2];
    assign ram_wdata = mem_wdata;
    assign ram_wmask = mem_wmask;

    assign tmr_we    = wr_accept && in_tmr;
    assign tmr_sel   = mem_addr[3:2];
    assign tmr_wdata = mem_wdata;

    assign mem_cmd_ready = !rd_p1;  // busy only while a read is in stage 1

    always_ff @(posedge clk) begin
        if (rst) begin
            rd_p1           <= 1'b0;
            mem_rdata_valid <= 1'b0;
        end else begin
            rd_p1           <= rd_accept;
            mem_rdata_valid <= rd_p1;
        end
    end

    always_ff @(posedge clk) begin
        if (rd_accept) begin
            p1_ram <= in_ram;
            p1_tmr <= in_tmr;
            tmr_q  <= tmr_rdata;  // matches the RAM's one cycle
        end
        if (rd_p1) begin
            if (p1_ram)
                mem_rdata <= ram_rdata;
            else if (p1_tmr)
                mem_rdata <= tmr_q;
            else
                mem_rdata <= READ_ALL_ONES;
        end
    end

endmodule

// ==== hdl/mem_arbiter.sv ====
`timescale 1ns/100ps

module mem_arbiter
    import mem_pkg::*;
(
    input  logic  clk,
    input  logic  rst,
    input  logic  exited,

    // fetch channel
    input  logic  inst_start,
    output logic  inst_ready,
    input  addr_t i_addr,
    output word_t inst,
    output logic  inst_valid,

    // data channel
    input  logic  d_cmd_start,
    input  logic  d_cmd_write,
    output logic  d_cmd_ready,
    input  addr_t d_addr,
    input  word_t wdata,
    input  mask_t wmask,
    output word_t rdata,
    output logic  rdata_valid,

    // shared memory port
    output logic  mem_cmd_start,
    output logic  mem_cmd_write,
    input  logic  mem_cmd_ready,
    output addr_t mem_addr,
    output word_t mem_wdata,
    output mask_t mem_wmask,
    input  word_t mem_rdata,
    input  logic  mem_rdata_valid
);

    arb_state_t state;
    logic       cmd_is_inst;   // command in flight is the fetch
    logic       save_d_start;  // a data command is waiting behind the fetch

    // commands saved in wait_cmd
    addr_t save_i_addr;
    logic  save_d_write;
    addr_t save_d_addr;
    word_t save_wdata;
    mask_t save_wmask;

    word_t inst_q;
    word_t rdata_q;

    logic  issue;
    logic  inst_done;
    logic  data_done;

    // both channels see the same ready
    assign inst_ready  = (state == wait_cmd);
    assign d_cmd_ready = (state == wait_cmd);

    always_comb begin
        issue         = 1'b0;
        mem_cmd_write = 1'b0;
        mem_addr      = save_d_addr;
        mem_wdata     = save_wdata;
        mem_wmask     = save_wmask;
        case (state)
            wait_cmd: begin
                issue         = mem_cmd_ready && (inst_start || d_cmd_start);
                mem_cmd_write = !inst_start && d_cmd_write;  // fetch goes first
                mem_addr      = inst_start ? i_addr : d_addr;
                mem_wdata     = wdata;
                mem_wmask     = wmask;
            end
            wait_ready: begin
                issue         = mem_cmd_ready;
                mem_cmd_write = !cmd_is_inst && save_d_write;
                mem_addr      = cmd_is_inst ? save_i_addr : save_d_addr;
            end
            wait_read: begin
                // data command follows right as the fetch word returns
                issue         = mem_rdata_valid && cmd_is_inst && save_d_start;
                mem_cmd_write = save_d_write;
            end
            default: ;
        endcase
    end

    assign mem_cmd_start = issue && !exited;  // frozen while exited

    assign inst_done = !exited && (state == wait_read) && mem_rdata_valid && cmd_is_inst;
    assign data_done = !exited && (state == wait_read) && mem_rdata_valid && !cmd_is_inst;

    assign inst_valid  = inst_done;
    assign rdata_valid = data_done;

    // new word shows in the pulse cycle, then the held copy
    assign inst  = inst_done ? mem_rdata : inst_q;
    assign rdata = data_done ? mem_rdata : rdata_q;

    always_ff @(posedge clk) begin
        if (rst) begin
            state        <= wait_cmd;
            cmd_is_inst  <= 1'b0;
            save_d_start <= 1'b0;
            inst_q       <= READ_ALL_ONES;
            rdata_q      <= READ_ALL_ONES;
        end else if (!exited) begin
            case (state)
                wait_cmd: begin
                    if (inst_start || d_cmd_start) begin
                        cmd_is_inst  <= inst_start;
                        save_d_start <= d_cmd_start;
                        if (!mem_cmd_ready)
                            state <= wait_ready;
                        else if (inst_start || !d_cmd_write)
                            state <= wait_read;  // lone write stays here
                    end
                end
                wait_ready: begin
                    if (mem_cmd_ready)
                        state <= (cmd_is_inst || !save_d_write) ? wait_read : wait_cmd;
                end
                wait_read: begin
                    if (mem_rdata_valid) begin
                        if (cmd_is_inst) begin
                            inst_q <= mem_rdata;
                            if (save_d_start) begin
                                cmd_is_inst <= 1'b0;
                                if (!mem_cmd_ready)
                                    state <= wait_ready;
                                else if (save_d_write)
                                    state <= wait_cmd;
                                // a data read keeps us in wait_read
                            end else begin
                                state <= wait_cmd;
                            end
                        end else begin
                            rdata_q <= mem_rdata;
                            state   <= wait_cmd;
                        end
                    end
                end
                default: state <= wait_cmd;
            endcase
        end
    end

    // payload capture, no reset needed
    always_ff @(posedge clk) begin
        if (!exited && state == wait_cmd) begin
            save_i_addr  <= i_addr;
            save_d_write <= d_cmd_write;
            save_d_addr  <= d_addr;
            save_wdata   <= wdata;
            save_wmask   <= wmask;
        end
    end

endmodule

// ==== hdl/mem_subsys_top.sv ====
`timescale 1ns/100ps

module mem_subsys_top
    import mem_pkg::*;
#(
    parameter int MEM_WORDS = 1024
) (
    input  logic  clk,
    input  logic  rst,
    input  logic  exited,

    input  logic  inst_start,
    output logic  inst_ready,
    input  addr_t i_addr,
    output word_t inst,
    output logic  inst_valid,

    input  logic  d_cmd_start,
    input  logic  d_cmd_write,
    output logic  d_cmd_ready,
    input  addr_t d_addr,
    input  word_t wdata,
    input  mask_t wmask,
    output word_t rdata,
    output logic  rdata_valid,

    output logic  timer_irq
);

    // arbiter to controller
    logic  mem_cmd_start;
    logic  mem_cmd_write;
    logic  mem_cmd_ready;
    addr_t mem_addr;
    word_t mem_wdata;
    mask_t mem_wmask;
    word_t mem_rdata;
    logic  mem_rdata_valid;

    // controller to RAM
    logic                         ram_we;
    logic                         ram_re;
    logic [$clog2(MEM_WORDS)-1:0] ram_index;
    word_t                        ram_wdata;
    mask_t                        ram_wmask;
    word_t                        ram_rdata;

    // controller to timer
    logic       tmr_we;
    logic [1:0] tmr_sel;
    word_t      tmr_wdata;
    word_t      tmr_rdata;

    mem_arbiter i_mem_arbiter (
        .clk             (clk),
        .rst             (rst),
        .exited          (exited),
        .inst_start      (inst_start),
        .inst_ready      (inst_ready),
        .i_addr          (i_addr),
        .inst            (inst),
        .inst_valid      (inst_valid),
        .d_cmd_start     (d_cmd_start),
        .d_cmd_write     (d_cmd_write),
        .d_cmd_ready     (d_cmd_ready),
        .d_addr          (d_addr),
        .wdata           (wdata),
        .wmask           (wmask),
        .rdata           (rdata),
        .rdata_valid     (rdata_valid),
        .mem_cmd_start   (mem_cmd_start),
        .mem_cmd_write   (mem_cmd_write),
        .mem_cmd_ready   (mem_cmd_ready),
        .mem_addr        (mem_addr),
        .mem_wdata       (mem_wdata),
        .mem_wmask       (mem_wmask),
        .mem_rdata       (mem_rdata),
        .mem_rdata_valid (mem_rdata_valid)
    );

    mem_map_ctrl #(
        .MEM_WORDS (MEM_WORDS)
    ) i_mem_map_ctrl (
        .clk             (clk),
        .rst             (rst),
        .mem_cmd_start   (mem_cmd_start),
        .mem_cmd_write   (mem_cmd_write),
        .mem_cmd_ready   (mem_cmd_ready),
        .mem_addr        (mem_addr),
        .mem_wdata       (mem_wdata),
        .mem_wmask       (mem_wmask),
        .mem_rdata       (mem_rdata),
        .mem_rdata_valid (mem_rdata_valid),
        .ram_we          (ram_we),
        .ram_re          (ram_re),
        .ram_index       (ram_index),
        .ram_wdata       (ram_wdata),
        .ram_wmask       (ram_wmask),
        .ram_rdata       (ram_rdata),
        .tmr_we          (tmr_we),
        .tmr_sel         (tmr_sel),
        .tmr_wdata       (tmr_wdata),
        .tmr_rdata       (tmr_rdata)
    );

    word_ram #(
        .MEM_WORDS (MEM_WORDS)
    ) i_word_ram (
        .clk       (clk),
        .ram_we    (ram_we),
        .ram_re    (ram_re),
        .ram_index (ram_index),
        .ram_wdata (ram_wdata),
        .ram_wmask (ram_wmask),
        .ram_rdata (ram_rdata)
    );

    timer_regs i_timer_regs (
        .clk       (clk),
        .rst       (rst),
        .tmr_we    (tmr_we),
        .tmr_sel   (tmr_sel),
        .tmr_wdata (tmr_wdata),
        .tmr_mask  (mem_wmask),  // straight from the port
        .tmr_rdata (tmr_rdata),
        .timer_irq (timer_irq)
    );

endmodule

// ==== verification/mem_subsys_assert.sv ====
`timescale 1ns/100ps

module mem_subsys_assert (
    input logic clk,
    input logic rst,
    input logic mem_cmd_start,
    input logic mem_cmd_write,
    input logic mem_cmd_ready,
    input logic inst_ready,
    input logic d_cmd_ready,
    input logic inst_valid,
    input logic rdata_valid
);

    int fail_count = 0;  // failed assertions so far

    // port starts only when the controller can take them
    start_needs_ready: assert property (
        @(posedge clk) disable iff (rst) mem_cmd_start |-> mem_cmd_ready
    ) else begin
        $error("mem_cmd_start high while mem_cmd_ready low");
        fail_count++;
    end

    // never both, and each pulse lasts one cycle
    one_valid_at_a_time: assert property (
        @(posedge clk) disable iff (rst)
        (inst_valid || rdata_valid) |->
            !(inst_valid && rdata_valid) ##1 !(inst_valid || rdata_valid)
    ) else begin
        $error("inst_valid and rdata_valid together or longer than one cycle");
        fail_count++;
    end

    // both channels busy once a read is on the port
    readies_match: assert property (
        @(posedge clk) disable iff (rst)
        (inst_ready == d_cmd_ready) &&
            !(inst_ready && $past(mem_cmd_start && !mem_cmd_write))
    ) else begin
        $error("channel readies differ or are high with a read in flight");
        fail_count++;
    end

    // first cycle out of reset
    quiet_after_reset: assert property (
        @(posedge clk) $fell(rst) |-> (!inst_valid && !rdata_valid)
    ) else begin
        $error("valid pulse in the cycle after reset");
        fail_count++;
    end

endmodule

bind mem_arbiter mem_subsys_assert i_mem_subsys_assert (
    .clk           (clk),
    .rst           (rst),
    .mem_cmd_start (mem_cmd_start),
    .mem_cmd_write (mem_cmd_write),
    .mem_cmd_ready (mem_cmd_ready),
    .inst_ready    (inst_ready),
    .d_cmd_ready   (d_cmd_ready),
    .inst_valid    (inst_valid),
    .rdata_valid   (rdata_valid)
);

// ==== verification/mem_subsys_tb.sv ====
`timescale 1ns/100ps

module mem_subsys_tb
    import mem_pkg::*;
();

    localparam int    MEM_WORDS    = 256;
    localparam int    RESET_CYCLES = 8;
    localparam int    WAIT_LIMIT   = 20;  // cycles allowed for one response
    localparam addr_t RAM_BYTES    = addr_t'(MEM_WORDS * 4);
    localparam addr_t CMP_LO       = TIMER_BASE + 32'd8;
    localparam addr_t CMP_HI       = TIMER_BASE + 32'd12;

    typedef enum logic [2:0] {
        op_write, op_read, op_fetch, op_fetch_read, op_fetch_write, op_irq, op_exit
    } op_t;

    typedef struct packed {
        op_t   op;
        addr_t i_addr;
        addr_t d_addr;
        word_t wdata;
        mask_t wmask;
        logic  fixed;  // expected word comes from the table
        word_t exp;    // bit 0 is the irq level for op_irq
    } step_t;

    logic  clk = 1'b0;
    logic  rst;
    logic  exited;
    logic  inst_start;
    logic  inst_ready;
    addr_t i_addr;
    word_t inst;
    logic  inst_valid;
    logic  d_cmd_start;
    logic  d_cmd_write;
    logic  d_cmd_ready;
    addr_t d_addr;
    word_t wdata;
    mask_t wmask;
    word_t rdata;
    logic  rdata_valid;
    logic  timer_irq;

    step_t  steps[$];
    word_t  ref_ram [MEM_WORDS];
    mtime_t ref_cmp;
    word_t  last_inst;   // held outputs as the model sees them
    word_t  last_rdata;
    int     seed;
    int     mismatches   = 0;
    int     other_errors = 0;
    int     assert_fails = 0;
    int     cycle_count  = 0;
    int     cycle_limit  = 0;

    always #2 clk = ~clk;  // 4 ns period

    mem_subsys_top #(
        .MEM_WORDS (MEM_WORDS)
    ) i_mem_subsys_top (
        .clk         (clk),
        .rst         (rst),
        .exited      (exited),
        .inst_start  (inst_start),
        .inst_ready  (inst_ready),
        .i_addr      (i_addr),
        .inst        (inst),
        .inst_valid  (inst_valid),
        .d_cmd_start (d_cmd_start),
        .d_cmd_write (d_cmd_write),
        .d_cmd_ready (d_cmd_ready),
        .d_addr      (d_addr),
        .wdata       (wdata),
        .wmask       (wmask),
        .rdata       (rdata),
        .rdata_valid (rdata_valid),
        .timer_irq   (timer_irq)
    );

    // run length guard
    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_limit > 0 && cycle_count >= cycle_limit) begin
            $display("timeout: the run did not finish within %0d cycles", cycle_limit);
            $display("Finished with errors");
            $finish;
        end
    end

    task automatic check_word(input string name, input word_t got, input word_t exp);
        if (got !== exp) begin
            $display("MISMATCH %s: got 0x%h expected 0x%h", name, got, exp);
            mismatches++;
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("MISMATCH %s: got 0x%h expected 0x%h", name, got, exp);
            mismatches++;
        end
    endtask

    task automatic report_error(input string msg);
        $display("ERROR at %0t: %s", $time, msg);
        other_errors++;
    endtask

    function automatic word_t model_read(input addr_t a);
        if (a < RAM_BYTES)
            return ref_ram[a >> 2];
        if (a[31:4] == TIMER_BASE[31:4] && a[3])
            return a[2] ? ref_cmp[63:32] : ref_cmp[31:0];  // only mtimecmp is modelled
        return READ_ALL_ONES;
    endfunction

    task automatic model_write(input addr_t a, input word_t d, input mask_t m);
        word_t old_w;
        word_t new_w;
        int    b;
        old_w = model_read(a);
        for (b = 0; b < 32; b++) begin
            new_w[b] = m[b] ? d[b] : old_w[b];  // masked bits only
        end
        if (a < RAM_BYTES)
            ref_ram[a >> 2] = new_w;
        else if (a[31:4] == TIMER_BASE[31:4] && a[3] && a[2])
            ref_cmp[63:32] = new_w;
        else if (a[31:4] == TIMER_BASE[31:4] && a[3])
            ref_cmp[31:0] = new_w;
    endtask

    function automatic word_t next_random();
        return word_t'($random(seed));
    endfunction

    task automatic add_step(input op_t op, input addr_t ia, input addr_t da, input word_t wd,
                            input mask_t wm, input logic fixed, input word_t exp);
        step_t s;
        s = '{op: op, i_addr: ia, d_addr: da, wdata: wd, wmask: wm, fixed: fixed, exp: exp};
        steps.push_back(s);
    endtask

    task automatic build_table;
        // masked writes, read back
        add_step(op_write, '0, 32'h010, next_random(), 32'hffff_ffff, 1'b0, '0);
        add_step(op_read,  '0, 32'h010, '0, '0, 1'b0, '0);
        add_step(op_write, '0, 32'h010, next_random(), 32'h0000_ffff, 1'b0, '0);
        add_step(op_read,  '0, 32'h010, '0, '0, 1'b0, '0);
        add_step(op_write, '0, 32'h010, next_random(), 32'h0f0f_f0f0, 1'b0, '0);
        add_step(op_read,  '0, 32'h010, '0, '0, 1'b0, '0);
        add_step(op_write, '0, 32'h010, next_random(), 32'h0000_0000, 1'b0, '0);
        add_step(op_read,  '0, 32'h010, '0, '0, 1'b0, '0);
        add_step(op_write, '0, 32'h3fc, next_random(), 32'hffff_ffff, 1'b0, '0);
        add_step(op_read,  '0, 32'h3fc, '0, '0, 1'b0, '0);
        // fetch sees the last write, inst held across data reads
        add_step(op_write, '0, 32'h020, next_random(), 32'hffff_ffff, 1'b0, '0);
        add_step(op_write, '0, 32'h020, next_random(), 32'hff00_00ff, 1'b0, '0);
        add_step(op_fetch, 32'h020, '0, '0, '0, 1'b0, '0);
        add_step(op_read,  '0, 32'h010, '0, '0, 1'b0, '0);
        add_step(op_read,  '0, 32'h3fc, '0, '0, 1'b0, '0);
        // both channels in one cycle
        add_step(op_write, '0, 32'h024, next_random(), 32'hffff_ffff, 1'b0, '0);
        add_step(op_write, '0, 32'h028, next_random(), 32'hffff_ffff, 1'b0, '0);
        add_step(op_fetch_read,  32'h024, 32'h028, '0, '0, 1'b0, '0);
        add_step(op_fetch_write, 32'h020, 32'h02c, next_random(), 32'hffff_ffff, 1'b0, '0);
        add_step(op_read,  '0, 32'h02c, '0, '0, 1'b0, '0);
        // mtimecmp and the interrupt
        add_step(op_write, '0, CMP_LO, next_random(), 32'hffff_0000, 1'b0, '0);
        add_step(op_read,  '0, CMP_LO, '0, '0, 1'b0, '0);
        add_step(op_write, '0, CMP_HI, next_random(), 32'hffff_ffff, 1'b0, '0);
        add_step(op_read,  '0, CMP_HI, '0, '0, 1'b0, '0);
        add_step(op_write, '0, CMP_HI, 32'h0000_0001, 32'hffff_ffff, 1'b0, '0);
        add_step(op_write, '0, CMP_LO, 32'h0000_0000, 32'hffff_ffff, 1'b0, '0);
        add_step(op_read,  '0, CMP_LO, '0, '0, 1'b0, '0);
        add_step(op_irq,   '0, '0, '0, '0, 1'b0, 32'd0);
        add_step(op_write, '0, CMP_HI, 32'h0000_0000, 32'hffff_ffff, 1'b0, '0);
        add_step(op_irq,   '0, '0, '0, '0, 1'b0, 32'd1);
        // unmapped space
        add_step(op_read,  '0, RAM_BYTES, '0, '0, 1'b1, READ_ALL_ONES);
        add_step(op_write, '0, RAM_BYTES, next_random(), 32'hffff_ffff, 1'b0, '0);
        add_step(op_read,  '0, 32'h000, '0, '0, 1'b0, '0);  // same index if decode were wrong
        add_step(op_read,  '0, TIMER_BASE + 32'd16, '0, '0, 1'b1, READ_ALL_ONES);
        // frozen by exited
        add_step(op_exit,  32'h024, 32'h028, '0, '0, 1'b0, '0);
        add_step(op_fetch, 32'h02c, '0, '0, '0, 1'b0, '0);
    endtask

    task automatic drive_cmd(input logic fetch, input logic data, input logic wr, input step_t s);
        @(posedge clk);
        inst_start  <= fetch;
        i_addr      <= s.i_addr;
        d_cmd_start <= data;
        d_cmd_write <= wr;
        d_addr      <= s.d_addr;
        wdata       <= s.wdata;
        wmask       <= s.wmask;
        @(posedge clk);
        inst_start  <= 1'b0;
        d_cmd_start <= 1'b0;
    endtask

    task automatic wait_idle;
        int n;
        n = 0;
        @(negedge clk);
        while (!(inst_ready && d_cmd_ready) && n < WAIT_LIMIT) begin
            @(negedge clk);
            n++;
        end
        if (n >= WAIT_LIMIT)
            report_error("arbiter did not return to wait_cmd");
    endtask

    task automatic collect_results(input logic want_i, input logic want_d,
                                   output word_t got_i, output word_t got_d,
                                   output int cyc_i, output int cyc_d);
        int n;
        cyc_i = -1;
        cyc_d = -1;
        got_i = '0;
        got_d = '0;
        for (n = 0; n < WAIT_LIMIT; n++) begin
            @(negedge clk);
            if (n == 0) begin
                // busy while a read is out, free again after a lone write
                check_bit("inst_ready", inst_ready, !(want_i || want_d));
                check_bit("d_cmd_ready", d_cmd_ready, !(want_i || want_d));
            end
            if (inst_valid) begin
                if (!want_i || cyc_i >= 0)
                    report_error("unexpected inst_valid pulse");
                cyc_i = n;
                got_i = inst;
            end
            if (rdata_valid) begin
                if (!want_d || cyc_d >= 0)
                    report_error("unexpected rdata_valid pulse");
                cyc_d = n;
                got_d = rdata;
            end
            if ((!want_i || cyc_i >= 0) && (!want_d || cyc_d >= 0))
                break;
        end
        if (want_i && cyc_i < 0)
            report_error("no inst_valid pulse within the wait limit");
        if (want_d && cyc_d < 0)
            report_error("no rdata_valid pulse within the wait limit");
        @(negedge clk);
        check_bit("inst_valid", inst_valid, 1'b0);  // one pulse only
        check_bit("rdata_valid", rdata_valid, 1'b0);
    endtask

    task automatic access_and_check(input logic fetch, input logic data, input logic wr,
                                    input step_t s);
        word_t exp_i;
        word_t exp_d;
        word_t got_i;
        word_t got_d;
        int    cyc_i;
        int    cyc_d;
        exp_i = model_read(s.i_addr);
        exp_d = s.fixed ? s.exp : model_read(s.d_addr);
        drive_cmd(fetch, data, wr, s);
        collect_results(fetch, data && !wr, got_i, got_d, cyc_i, cyc_d);
        if (fetch) begin
            check_word("inst", got_i, exp_i);
            last_inst = exp_i;
        end else begin
            check_word("inst", inst, last_inst);  // held value
        end
        if (data && !wr) begin
            check_word("rdata", got_d, exp_d);
            last_rdata = exp_d;
        end else begin
            check_word("rdata", rdata, last_rdata);
        end
        if (fetch && data && !wr && cyc_i >= 0 && cyc_d >= 0 && cyc_i >= cyc_d)
            report_error("inst_valid did not come before rdata_valid");
        if (data && wr)
            model_write(s.d_addr, s.wdata, s.wmask);
    endtask

    task automatic check_irq(input logic level);
        int n;
        for (n = 0; n < 3; n++) begin
            @(negedge clk);
            if (level && timer_irq)
                break;
        end
        check_bit("timer_irq", timer_irq, level);
    endtask

    task automatic run_frozen(input step_t s);
        int n;
        @(posedge clk);
        exited <= 1'b1;
        drive_cmd(1'b1, 1'b1, 1'b0, s);  // not taken while exited
        for (n = 0; n < 10; n++) begin
            @(negedge clk);
            if (inst_valid || rdata_valid)
                report_error("valid pulse while exited was high");
        end
        @(posedge clk);
        exited <= 1'b0;
        access_and_check(1'b0, 1'b1, 1'b0, s);
    endtask

    task automatic run_step(input step_t s);
        wait_idle();
        case (s.op)
            op_write:       access_and_check(1'b0, 1'b1, 1'b1, s);
            op_read:        access_and_check(1'b0, 1'b1, 1'b0, s);
            op_fetch:       access_and_check(1'b1, 1'b0, 1'b0, s);
            op_fetch_read:  access_and_check(1'b1, 1'b1, 1'b0, s);
            op_fetch_write: access_and_check(1'b1, 1'b1, 1'b1, s);
            op_irq:         check_irq(s.exp[0]);
            default:        run_frozen(s);
        endcase
    endtask

    initial begin
        rst         = 1'b1;
        exited      = 1'b0;
        inst_start  = 1'b0;
        i_addr      = '0;
        d_cmd_start = 1'b0;
        d_cmd_write = 1'b0;
        d_addr      = '0;
        wdata       = '0;
        wmask       = '0;
        seed        = 32'hbb364692;
        for (int i = 0; i < MEM_WORDS; i++) begin
            ref_ram[i] = '0;
        end
        ref_cmp    = '1;
        last_inst  = READ_ALL_ONES;
        last_rdata = READ_ALL_ONES;
        build_table();
        cycle_limit = 40 * steps.size() + RESET_CYCLES;

        repeat (RESET_CYCLES) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        check_word("inst", inst, READ_ALL_ONES);
        check_word("rdata", rdata, READ_ALL_ONES);
        check_bit("timer_irq", timer_irq, 1'b0);

        foreach (steps[i]) begin
            run_step(steps[i]);
        end

        assert_fails = i_mem_subsys_top.i_mem_arbiter.i_mem_subsys_assert.fail_count;
        $display("%0d steps run, %0d mismatches, %0d other errors, %0d assertion failures",
                 steps.size(), mismatches, other_errors, assert_fails);
        if (mismatches == 0 && other_errors == 0 && assert_fails == 0)
            $display("Finished with no errors");
        else
            $display("Finished with errors");
        $finish;
    end

endmodule

// ==== flist.f ====
hdl/mem_pkg.sv
hdl/word_ram.sv
hdl/timer_regs.sv
hdl/mem_map_ctrl.sv
hdl/mem_arbiter.sv
hdl/mem_subsys_top.sv
verification/mem_subsys_assert.sv
verification/mem_subsys_tb.sv

// ==== Bender.yml ====
package:
  name: mem_subsys

sources:
  # RTL in compile order
  - files:
      - hdl/mem_pkg.sv
      - hdl/word_ram.sv
      - hdl/timer_regs.sv
      - hdl/mem_map_ctrl.sv
      - hdl/mem_arbiter.sv
      - hdl/mem_subsys_top.sv

  # testbench and bound assertions
  - target: test
    files:
      - verification/mem_subsys_assert.sv
      - verification/mem_subsys_tb.sv
